// File: ifetch_pkg.sv
package ifetch_pkg;

  // word sizes of the fetch path
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // the one instruction the fetch unit decodes
  localparam logic [DATA_W-1:0] FENCE_I = 32'h0000100f;

  // axi4-lite encodings
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
  // unprivileged, secure, instruction access
  localparam logic [2:0] AXI_PROT_INSN = 3'b100;

  // core side
  typedef struct packed {
    logic [ADDR_W-1:0] pc;
  } fetch_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] inst;
    logic              err;
  } fetch_rsp_t;

  // cache to bus master
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } refill_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              err;
  } refill_rsp_t;

  // axi4-lite read channels
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } axil_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axil_r_t;

  typedef enum logic [1:0] {
    CACHE_IDLE,
    CACHE_REFILL_LO,
    CACHE_REFILL_HI
  } icache_state_e;

  typedef enum logic [1:0] {
    IFU_IDLE,
    IFU_LOOKUP,
    IFU_WAIT_READY
  } ifu_state_e;

endpackage

// File: icache.sv
module icache #(
  parameter int NUM_LINES = 8
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           lookup_valid_i,
  input  logic [ifetch_pkg::ADDR_W-1:0]  lookup_pc_i,
  output logic                           hit_valid_o,
  output logic [ifetch_pkg::DATA_W-1:0]  hit_inst_o,
  output logic                           hit_err_o,
  input  logic                           flush_i,
  output logic                           refill_valid_o,
  output ifetch_pkg::refill_req_t        refill_req_o,
  input  logic                           refill_done_i,
  input  ifetch_pkg::refill_rsp_t        refill_rsp_i
);
  import ifetch_pkg::*;

  // pc layout: tag | index | word select | byte offset
  localparam int IDX_W  = $clog2(NUM_LINES);
  localparam int LINE_W = ADDR_W - 3;
  localparam int TAG_W  = LINE_W - IDX_W;

  icache_state_e state_q;

  logic [DATA_W-1:0] data_lo_q [NUM_LINES];
  logic [DATA_W-1:0] data_hi_q [NUM_LINES];
  logic [TAG_W-1:0]  tag_q     [NUM_LINES];
  logic [NUM_LINES-1:0] valid_q;

  logic              err_pending_q;
  logic              refill_issue_q;
  logic [LINE_W-1:0] line_addr_q;

  logic [TAG_W-1:0] lookup_tag;
  logic [IDX_W-1:0] lookup_idx;
  logic             lookup_word;
  logic             line_hit;
  logic             miss;
  logic [TAG_W-1:0] refill_tag;
  logic [IDX_W-1:0] refill_idx;

  assign lookup_tag  = lookup_pc_i[ADDR_W-1 -: TAG_W];
  assign lookup_idx  = lookup_pc_i[3 +: IDX_W];
  assign lookup_word = lookup_pc_i[2];

  assign refill_tag = line_addr_q[LINE_W-1 -: TAG_W];
  assign refill_idx = line_addr_q[IDX_W-1:0];

  assign line_hit = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);

  // a failed refill answers the waiting lookup once, with the error flag
  assign hit_valid_o = lookup_valid_i && (state_q == CACHE_IDLE) &&
                       (line_hit || err_pending_q);
  assign hit_err_o   = err_pending_q;
  assign hit_inst_o  = err_pending_q ? '0 :
                       (lookup_word ? data_hi_q[lookup_idx] : data_lo_q[lookup_idx]);

  assign miss = lookup_valid_i && (state_q == CACHE_IDLE) && !line_hit && !err_pending_q;

  // even word first, then the odd one
  assign refill_valid_o    = refill_issue_q;
  assign refill_req_o.addr = {line_addr_q, (state_q == CACHE_REFILL_HI), 2'b00};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q        <= CACHE_IDLE;
      valid_q        <= '0;
      err_pending_q  <= 1'b0;
      refill_issue_q <= 1'b0;
    end
    else
    begin
      refill_issue_q <= 1'b0;
      // flush clears everything; a refill finishing now still validates its line
      if (flush_i)
      begin
        valid_q <= '0;
      end
      case (state_q)
        CACHE_IDLE:
        begin
          if (err_pending_q && hit_valid_o)
          begin
            err_pending_q <= 1'b0;
          end
          else if (miss)
          begin
            // old contents are overwritten word by word
            valid_q[lookup_idx] <= 1'b0;
            refill_issue_q      <= 1'b1;
            state_q             <= CACHE_REFILL_LO;
          end
        end
        CACHE_REFILL_LO:
        begin
          if (refill_done_i)
          begin
            if (refill_rsp_i.err)
            begin
              err_pending_q <= 1'b1;
              state_q       <= CACHE_IDLE;
            end
            else
            begin
              refill_issue_q <= 1'b1;
              state_q        <= CACHE_REFILL_HI;
            end
          end
        end
        CACHE_REFILL_HI:
        begin
          if (refill_done_i)
          begin
            if (refill_rsp_i.err)
            begin
              err_pending_q <= 1'b1;
            end
            else
            begin
              valid_q[refill_idx] <= 1'b1;
            end
            state_q <= CACHE_IDLE;
          end
        end
        default:
        begin
          state_q <= CACHE_IDLE;
        end
      endcase
    end
  end

  // line storage
  always_ff @(posedge clk)
  begin
    if (miss)
    begin
      line_addr_q <= lookup_pc_i[ADDR_W-1:3];
    end
    if (state_q == CACHE_REFILL_LO && refill_done_i && !refill_rsp_i.err)
    begin
      data_lo_q[refill_idx] <= refill_rsp_i.data;
    end
    if (state_q == CACHE_REFILL_HI && refill_done_i && !refill_rsp_i.err)
    begin
      data_hi_q[refill_idx] <= refill_rsp_i.data;
      tag_q[refill_idx]     <= refill_tag;
    end
  end

  a_refill_in_refill: assert property (@(posedge clk) disable iff (rst)
    refill_valid_o |-> (state_q != CACHE_IDLE))
    else $error("refill request outside a refill");

  a_hit_needs_lookup: assert property (@(posedge clk) disable iff (rst)
    hit_valid_o |-> lookup_valid_i)
    else $error("hit without lookup");

endmodule

// File: axil_read_master.sv
module axil_read_master (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     refill_valid_i,
  input  ifetch_pkg::refill_req_t  refill_req_i,
  output logic                     refill_done_o,
  output ifetch_pkg::refill_rsp_t  refill_rsp_o,
  output logic                     arvalid_o,
  input  logic                     arready_i,
  output ifetch_pkg::axil_ar_t     ar_o,
  input  logic                     rvalid_i,
  output logic                     rready_o,
  input  ifetch_pkg::axil_r_t      r_i
);
  import ifetch_pkg::*;

  logic     arvalid_q;
  logic     rready_q;
  axil_ar_t ar_q;
  logic     busy;

  // one transaction at a time
  assign busy = arvalid_q || rready_q;

  assign arvalid_o = arvalid_q;
  assign rready_o  = rready_q;
  assign ar_o      = ar_q;

  // data comes straight off the r channel
  assign refill_done_o     = rvalid_i && rready_q;
  assign refill_rsp_o.data = r_i.data;
  assign refill_rsp_o.err  = (r_i.resp != AXI_RESP_OKAY);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
    end
    else
    begin
      if (refill_valid_i && !busy)
      begin
        arvalid_q <= 1'b1;
      end
      // address accepted, wait for the data beat
      if (arvalid_q && arready_i)
      begin
        arvalid_q <= 1'b0;
        rready_q  <= 1'b1;
      end
      if (rready_q && rvalid_i)
      begin
        rready_q <= 1'b0;
      end
    end
  end

  // address payload
  always_ff @(posedge clk)
  begin
    if (refill_valid_i && !busy)
    begin
      ar_q.addr <= refill_req_i.addr;
      ar_q.prot <= AXI_PROT_INSN;
    end
  end

  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
    else $error("AR payload changed before handshake");

  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    refill_valid_i |-> !busy)
    else $error("refill request while a read is in flight");

endmodule

// File: ifu.sv
module ifu (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  ifetch_pkg::fetch_req_t         req_i,
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  output ifetch_pkg::fetch_rsp_t         rsp_o,
  output logic                           lookup_valid_o,
  output logic [ifetch_pkg::ADDR_W-1:0]  lookup_pc_o,
  input  logic                           hit_valid_i,
  input  logic [ifetch_pkg::DATA_W-1:0]  hit_inst_i,
  input  logic                           hit_err_i,
  output logic                           flush_o
);
  import ifetch_pkg::*;

  ifu_state_e state_q;
  ifu_state_e state_d;
  logic              ready_q;
  logic [ADDR_W-1:0] pc_q;
  fetch_rsp_t        rsp_q;
  logic              req_fire;
  logic              rsp_fire;

  assign req_fire = req_valid_i && req_ready_o;
  assign rsp_fire = rsp_valid_o && rsp_ready_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IFU_IDLE:
        if (req_fire)
          state_d = IFU_LOOKUP;
      IFU_LOOKUP:
        if (hit_valid_i)
          state_d = IFU_WAIT_READY;
      IFU_WAIT_READY:
        if (rsp_ready_i)
          state_d = IFU_IDLE;
      default:
        state_d = IFU_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= IFU_IDLE;
      ready_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // registered copy of the idle state, low right after reset
      ready_q <= (state_d == IFU_IDLE);
    end
  end

  // pc and response payload
  always_ff @(posedge clk)
  begin
    if (req_fire)
    begin
      pc_q <= req_i.pc;
    end
    if (state_q == IFU_LOOKUP && hit_valid_i)
    begin
      rsp_q.pc   <= pc_q;
      rsp_q.inst <= hit_inst_i;
      rsp_q.err  <= hit_err_i;
    end
  end

  assign req_ready_o    = ready_q;
  assign lookup_valid_o = (state_q == IFU_LOOKUP);
  assign lookup_pc_o    = pc_q;
  assign rsp_valid_o    = (state_q == IFU_WAIT_READY);
  assign rsp_o          = rsp_q;

  // fence.i handed to the core invalidates the whole cache
  assign flush_o = rsp_fire && (rsp_q.inst == FENCE_I) && !rsp_q.err;

  a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("fetch response changed under back-pressure");

endmodule

// File: ifetch_top.sv
module ifetch_top #(
  parameter int NUM_LINES = 8
) (
  input  logic                    clk,
  input  logic                    rst,
  // core side
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  ifetch_pkg::fetch_req_t  req_i,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output ifetch_pkg::fetch_rsp_t  rsp_o,
  // instruction memory, axi4-lite read
  output logic                    arvalid_o,
  input  logic                    arready_i,
  output ifetch_pkg::axil_ar_t    ar_o,
  input  logic                    rvalid_i,
  output logic                    rready_o,
  input  ifetch_pkg::axil_r_t     r_i
);
  import ifetch_pkg::*;

  logic              lookup_valid;
  logic [ADDR_W-1:0] lookup_pc;
  logic              hit_valid;
  logic [DATA_W-1:0] hit_inst;
  logic              hit_err;
  logic              flush;
  logic              refill_valid;
  refill_req_t       refill_req;
  logic              refill_done;
  refill_rsp_t       refill_rsp;

  ifu ifu_inst (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_i          (req_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_o          (rsp_o),
    .lookup_valid_o (lookup_valid),
    .lookup_pc_o    (lookup_pc),
    .hit_valid_i    (hit_valid),
    .hit_inst_i     (hit_inst),
    .hit_err_i      (hit_err),
    .flush_o        (flush)
  );

  icache #(
    .NUM_LINES (NUM_LINES)
  ) icache_inst (
    .clk            (clk),
    .rst            (rst),
    .lookup_valid_i (lookup_valid),
    .lookup_pc_i    (lookup_pc),
    .hit_valid_o    (hit_valid),
    .hit_inst_o     (hit_inst),
    .hit_err_o      (hit_err),
    .flush_i        (flush),
    .refill_valid_o (refill_valid),
    .refill_req_o   (refill_req),
    .refill_done_i  (refill_done),
    .refill_rsp_i   (refill_rsp)
  );

  axil_read_master axil_read_master_inst (
    .clk            (clk),
    .rst            (rst),
    .refill_valid_i (refill_valid),
    .refill_req_i   (refill_req),
    .refill_done_o  (refill_done),
    .refill_rsp_o   (refill_rsp),
    .arvalid_o      (arvalid_o),
    .arready_i      (arready_i),
    .ar_o           (ar_o),
    .rvalid_i       (rvalid_i),
    .rready_o       (rready_o),
    .r_i            (r_i)
  );

endmodule

// File: tb_ifetch.sv
module tb_ifetch;
  import ifetch_pkg::*;

  localparam int NUM_LINES        = 8;
  localparam int MEM_WORDS        = 1024;
  localparam int CYCLES_PER_FETCH = 200;

  logic       clk;
  logic       rst;
  logic       req_valid_i;
  logic       req_ready_o;
  fetch_req_t req_i;
  logic       rsp_valid_o;
  logic       rsp_ready_i;
  fetch_rsp_t rsp_o;
  logic       arvalid_o;
  logic       arready_i;
  axil_ar_t   ar_o;
  logic       rvalid_i;
  logic       rready_o;
  axil_r_t    r_i;

  // instruction memory model with one word per entry
  logic [31:0] mem    [MEM_WORDS];
  logic        slverr [MEM_WORDS];

  // commands parsed from the input file
  byte         cmd_kind [$];
  string       cmd_name [$];
  logic [31:0] cmd_addr [$];
  logic [31:0] cmd_data [$];
  logic        cmd_err  [$];

  int cycle_limit;

  ifetch_top #(
    .NUM_LINES (NUM_LINES)
  ) ifetch_top_inst (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .arvalid_o   (arvalid_o),
    .arready_i   (arready_i),
    .ar_o        (ar_o),
    .rvalid_i    (rvalid_i),
    .rready_o    (rready_o),
    .r_i         (r_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0])
      return (state >> 1) ^ 16'hb400;
    else
      return state >> 1;
  endfunction

  function automatic int mem_index(input logic [31:0] addr);
    return int'(addr >> 2);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual)
      abort_run($sformatf("FAILED %s: expected %08h, actual %08h", name, expected, actual));
  endtask

  task automatic run_fetch(input string name, input logic [31:0] pc,
                           input logic [31:0] exp_inst, input logic exp_err);
    fetch_rsp_t got;
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_i.pc    <= pc;
    // handshake on the edge after ready is seen high
    do
      @(negedge clk);
    while (!req_ready_o);
    @(posedge clk);
    req_valid_i <= 1'b0;
    do
      @(negedge clk);
    while (!(rsp_valid_o && rsp_ready_i));
    got = rsp_o;
    @(posedge clk);
    check({name, " pc"}, pc, got.pc);
    check({name, " inst"}, exp_inst, got.inst);
    check({name, " err"}, {31'b0, exp_err}, {31'b0, got.err});
  endtask

  // axi4-lite read slave plus random stalls on both sides
  initial
  begin : bus_model
    logic [15:0] lfsr;
    logic [31:0] rd_addr;
    logic        rd_pending;
    int          rd_delay;
    lfsr        = 16'd82;
    rd_addr     = '0;
    rd_pending  = 1'b0;
    rd_delay    = 0;
    arready_i   = 1'b0;
    rvalid_i    = 1'b0;
    r_i         = '0;
    rsp_ready_i = 1'b0;
    forever
    begin
      @(posedge clk);
      if (rst)
      begin
        arready_i   <= 1'b0;
        rvalid_i    <= 1'b0;
        rsp_ready_i <= 1'b0;
        rd_pending  = 1'b0;
      end
      else
      begin
        if (arvalid_o && arready_i)
        begin
          if (ar_o.addr >= MEM_WORDS * 4)
            abort_run($sformatf("read from %08h lies outside the memory model", ar_o.addr));
          check("ar prot", 32'h4, {29'b0, ar_o.prot});
          rd_addr    = ar_o.addr;
          rd_pending = 1'b1;
          lfsr       = lfsr_step(lfsr);
          rd_delay   = lfsr[0];
          lfsr       = lfsr_step(lfsr);
          rd_delay   = rd_delay * 2 + lfsr[0];
        end
        if (rvalid_i && rready_o)
        begin
          rvalid_i <= 1'b0;
        end
        else if (rd_pending && !rvalid_i)
        begin
          if (rd_delay == 0)
          begin
            rvalid_i   <= 1'b1;
            r_i.data   <= mem[mem_index(rd_addr)];
            r_i.resp   <= slverr[mem_index(rd_addr)] ? 2'b10 : 2'b00;
            rd_pending = 1'b0;
          end
          else
          begin
            rd_delay--;
          end
        end
        lfsr = lfsr_step(lfsr);
        rsp_ready_i <= lfsr[0];
        lfsr = lfsr_step(lfsr);
        arready_i <= lfsr[0];
      end
    end
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    forever
    begin
      @(posedge clk);
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit)
        abort_run($sformatf("run timed out after %0d cycles", cycles));
    end
  end

  initial
  begin : stimulus
    int          fd;
    int          n;
    int          fetches;
    string       line;
    string       name;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] err;
    rst         = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    cycle_limit = 0;
    fetches     = 0;
    // fill pattern carries the byte address
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem[i]    = 32'hc0de_0000 | (i << 2);
      slverr[i] = 1'b0;
    end

    fd = $fopen("ifetch_input.txt", "r");
    if (fd == 0)
      abort_run("cannot open ifetch_input.txt");
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line[0] == "#" || line[0] == "\n")
        continue;
      name = "";
      data = '0;
      err  = '0;
      case (line[0])
        "W":     n = $sscanf(line, "W %h %h", addr, data) - 1;
        "E":     n = $sscanf(line, "E %h", addr);
        "F":     n = $sscanf(line, "F %s %h %h %h", name, addr, data, err) - 3;
        default: n = 0;
      endcase
      if (n != 1 || addr >= MEM_WORDS * 4)
        abort_run($sformatf("cannot use input line: %s", line));
      if (line[0] == "F")
        fetches++;
      cmd_kind.push_back(line[0]);
      cmd_name.push_back(name);
      cmd_addr.push_back(addr);
      cmd_data.push_back(data);
      cmd_err.push_back(err[0]);
    end
    $fclose(fd);
    cycle_limit = fetches * CYCLES_PER_FETCH;

    repeat (8) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < cmd_kind.size(); i++)
    begin
      case (cmd_kind[i])
        "W":
        begin
          mem[mem_index(cmd_addr[i])]    = cmd_data[i];
          slverr[mem_index(cmd_addr[i])] = 1'b0;
        end
        "E":
          slverr[mem_index(cmd_addr[i])] = 1'b1;
        default:
          run_fetch(cmd_name[i], cmd_addr[i], cmd_data[i], cmd_err[i]);
      endcase
    end

    if (fetches == 0)
      abort_run("input file holds no fetch commands");
    else
    begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: ifetch_input.txt
# W addr data          write a memory word and clear its error mark
# E addr               reads of this word answer SLVERR
# F name pc inst err   fetch pc, expect inst and the error bit
W 00000100 00500093
W 00000104 00a00113
W 00000108 002081b3
W 0000010c 40208233
F cold_even 00000100 00500093 0
F cold_odd 0000010c 40208233 0
F hit_odd 00000104 00a00113 0
F hit_even 00000108 002081b3 0
W 00000104 11111113
F stale_word 00000104 00a00113 0
W 00000140 00100513
W 00000144 00200593
F conflict_a 00000144 00200593 0
F conflict_back 00000104 11111113 0
F conflict_b 00000140 00100513 0
W 00000110 00c00693
W 00000114 00d00713
F fill_fence_line 00000110 00c00693 0
W 00000110 00e00693
W 00000140 00700513
W 00000118 0000100f
F stale_before_fence 00000110 00c00693 0
F fence_i 00000118 0000100f 0
F after_fence 00000110 00e00693 0
F after_fence_other 00000140 00700513 0
F fill_word 0000011c c0de011c 0
E 00000208
W 0000020c 00f00793
F bus_error 0000020c 00000000 1
W 00000208 01000813
F after_error 0000020c 00f00793 0
F after_error_even 00000208 01000813 0
W 00000230 01100893
E 00000234
F error_hi 00000230 00000000 1
W 00000234 01200913
F error_hi_retry 00000230 01100893 0
F error_hi_odd 00000234 01200913 0
W 00000120 00108093
W 00000124 00210113
W 00000128 00318193
W 0000012c 00420213
F stream_0 00000120 00108093 0
F stream_1 00000124 00210113 0
F stream_2 00000128 00318193 0
F stream_3 0000012c 00420213 0
F stream_1_again 00000124 00210113 0

// File: filelist.f
ifetch_pkg.sv
icache.sv
axil_read_master.sv
ifu.sv
ifetch_top.sv
tb_ifetch.sv

// File: Bender.yml
package:
  name: ifetch

# instruction fetch unit with L1 cache and AXI4-Lite read master
sources:
  - files:
      - ifetch_pkg.sv
      - icache.sv
      - axil_read_master.sv
      - ifu.sv
      - ifetch_top.sv

  # testbench reads ifetch_input.txt from the project root
  - target: test
    files:
      - tb_ifetch.sv
